//--- design/bram_sequencer.sv
// Backup-RAM sequencer
// Moves 128 sectors between battery RAM and the save image
`include "cart_macros.svh"
`default_nettype none

module bram_sequencer import cart_pkg::*; (
	input  wire logic      clk_sys,
	input  wire logic      RESET,
	input  wire logic      cart_download,
	input  wire logic      svp_quirk,
	input  wire logic      img_mounted,
	input  wire logic      img_readonly,
	input  wire img_size_t img_size,
	input  wire logic      bk_load,
	input  wire logic      bk_save,
	input  wire logic      sd_ack,
	output logic           sd_rd,
	output logic           sd_wr,
	output sector_t        sd_lba,
	output logic           bk_loading,
	output logic           bk_busy
);

	bk_state_t state;
	logic      bk_ena;
	logic      dl_q;
	logic      load_q;
	logic      save_q;
	logic      ack_q;
	logic      load_rise;
	logic      save_rise;

	assign load_rise = bk_load & ~load_q;
	assign save_rise = bk_save & ~save_q;
	assign bk_busy   = (state == BK_XFER);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= BK_IDLE;
			bk_ena     <= 1'b0;
			{dl_q, load_q, save_q, ack_q} <= 4'b0000;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			bk_loading <= 1'b0;
		end else begin
			dl_q   <= cart_download;
			load_q <= bk_load;
			save_q <= bk_save;
			ack_q  <= sd_ack;

			////////////////////
			// Save image enable
			if (!dl_q && cart_download) bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly && !svp_quirk) bk_ena <= 1'b1;
			if (cart_download && svp_quirk) bk_ena <= 1'b0; // SVP titles keep no backup RAM

			if (!ack_q && sd_ack) {sd_rd, sd_wr} <= 2'b00; // Request taken

			case (state)
				BK_IDLE: begin
					if (bk_ena && (load_rise || save_rise)) begin
						state      <= BK_XFER;
						bk_loading <= load_rise;
						sd_lba     <= '0;
						sd_rd      <= load_rise;
						sd_wr      <= ~load_rise;
					end
					if (dl_q && !cart_download && |img_size && bk_ena) begin
						state      <= BK_XFER; // Auto load after download
						bk_loading <= 1'b1;
						sd_lba     <= '0;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
					end
				end
				BK_XFER: begin
					if (ack_q && !sd_ack) begin
						if (sd_lba == `BRAM_LAST_SECTOR) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 7'd1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/cart_header_parser.sv
// Cartridge header parser
// Region letters, product code capture and per-title quirk lookup
`include "cart_macros.svh"
`default_nettype none

module cart_header_parser import cart_pkg::*; (
	input  wire logic        clk_sys,
	input  wire logic        RESET,
	input  wire logic        cart_download,
	input  wire logic        ioctl_wr,
	input  wire ioctl_addr_t ioctl_addr,
	input  wire ioctl_data_t ioctl_data,
	output logic             hdr_j,
	output logic             hdr_u,
	output logic             hdr_e,
	output logic             hdr_ready,
	output logic             sram_quirk,
	output logic             eeprom_quirk,
	output logic             svp_quirk,
	output logic             fmbusy_quirk,
	output logic             gun_type,
	output gun_delay_t       gun_sensor_delay
);

	logic       dl_q;
	logic       hdr_wr;
	logic [7:0] lo_ch;
	logic [7:0] hi_ch;
	cart_id_t   cart_id;

	logic       id_sram;
	logic       id_eeprom;
	logic       id_svp;
	logic       id_fmbusy;
	logic       gun_type_nxt;
	gun_delay_t gun_delay_nxt;

	assign hdr_wr = ioctl_wr & cart_download;
	assign lo_ch  = ioctl_data[7:0];
	assign hi_ch  = ioctl_data[15:8];

	////////////////////
	// Table lookup on the captured code
	assign id_sram   = (cart_id == `ID_SRAM_0)   || (cart_id == `ID_SRAM_1);
	assign id_eeprom = (cart_id == `ID_EEPROM_0) || (cart_id == `ID_EEPROM_1);
	assign id_svp    = (cart_id == `ID_SVP_0)    || (cart_id == `ID_SVP_1);
	assign id_fmbusy = (cart_id == `ID_FMBUSY_0) || (cart_id == `ID_FMBUSY_1);

	always_comb begin
		gun_type_nxt  = 1'b0;
		gun_delay_nxt = `GUN_DELAY_DEFAULT;
		case (cart_id)
			`ID_GUN_0: begin
				gun_type_nxt  = `GUN_TYPE_0;
				gun_delay_nxt = `GUN_DELAY_0;
			end
			`ID_GUN_1: begin
				gun_type_nxt  = `GUN_TYPE_1;
				gun_delay_nxt = `GUN_DELAY_1;
			end
			`ID_GUN_2: begin
				gun_type_nxt  = `GUN_TYPE_2;
				gun_delay_nxt = `GUN_DELAY_2;
			end
			default: ;
		endcase
	end

	// Code characters are stored byte-swapped in each word
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			if (ioctl_addr == `CART_ID_ADDR_0) cart_id[63:56] <= hi_ch;
			if (ioctl_addr == `CART_ID_ADDR_1) cart_id[55:40] <= {lo_ch, hi_ch};
			if (ioctl_addr == `CART_ID_ADDR_2) cart_id[39:24] <= {lo_ch, hi_ch};
			if (ioctl_addr == `CART_ID_ADDR_3) cart_id[23:8]  <= {lo_ch, hi_ch};
			if (ioctl_addr == `CART_ID_ADDR_4) cart_id[7:0]   <= lo_ch;
		end
	end

	////////////////////
	// Region letters, ready flag and quirks
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q             <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			hdr_ready        <= 1'b0;
			{sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk} <= 4'b0000;
			gun_type         <= 1'b0;
			gun_sensor_delay <= `GUN_DELAY_DEFAULT;
		end else begin
			dl_q <= cart_download;
			if (!dl_q && cart_download) begin // New download starts
				{hdr_j, hdr_u, hdr_e} <= 3'b000;
				{sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk} <= 4'b0000;
			end
			if (dl_q && !cart_download) hdr_ready <= 1'b0;

			if (hdr_wr) begin
				if (ioctl_addr == `HDR_REGION_ADDR_A || ioctl_addr == `HDR_REGION_ADDR_B) begin
					if (lo_ch == "J") hdr_j <= 1'b1;
					else if (lo_ch == "U") hdr_u <= 1'b1;
					else if (lo_ch >= "0" && lo_ch <= "Z") hdr_e <= 1'b1;
				end
				if (ioctl_addr == `HDR_REGION_ADDR_A) begin
					if (hi_ch == "J") hdr_j <= 1'b1;
					else if (hi_ch == "U") hdr_u <= 1'b1;
					else if (hi_ch >= "0" && hi_ch <= "Z") hdr_e <= 1'b1;
				end
				if (ioctl_addr == `CART_ID_DONE_ADDR) begin
					if (id_sram) sram_quirk <= 1'b1;
					else if (id_eeprom) eeprom_quirk <= 1'b1;
					else if (id_svp) svp_quirk <= 1'b1;
					else if (id_fmbusy) fmbusy_quirk <= 1'b1;
					gun_type         <= gun_type_nxt;
					gun_sensor_delay <= gun_delay_nxt;
				end
				if (ioctl_addr == `HDR_END_ADDR) hdr_ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/cart_loader_top.sv
// Cartridge loader top level
// Header parser, region selector, ROM write pacer and backup-RAM sequencer
`default_nettype none

module cart_loader_top import cart_pkg::*; (
	input  wire logic         clk_sys,
	input  wire logic         RESET,
	input  wire logic         cart_download,
	input  wire logic         ioctl_wr,
	input  wire ioctl_addr_t  ioctl_addr,
	input  wire ioctl_data_t  ioctl_data,
	input  wire logic [7:0]   ioctl_index,
	input  wire auto_region_t auto_region,
	input  wire logic [1:0]   region_priority,
	input  wire logic         rom_wrack,
	input  wire logic         img_mounted,
	input  wire logic         img_readonly,
	input  wire img_size_t    img_size,
	input  wire logic         bk_load,
	input  wire logic         bk_save,
	input  wire logic         sd_ack,
	output logic              ioctl_wait,
	output logic              rom_wr,
	output ioctl_addr_t       rom_sz,
	output region_t           region_req,
	output logic              region_set,
	output logic              sram_quirk,
	output logic              eeprom_quirk,
	output logic              svp_quirk,
	output logic              fmbusy_quirk,
	output logic              gun_type,
	output gun_delay_t        gun_sensor_delay,
	output logic              sd_rd,
	output logic              sd_wr,
	output sector_t           sd_lba,
	output logic              bk_loading,
	output logic              bk_busy
);

	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	cart_header_parser u_cart_header_parser (
		.clk_sys, .RESET, .cart_download, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.hdr_j, .hdr_u, .hdr_e, .hdr_ready,
		.sram_quirk, .eeprom_quirk, .svp_quirk, .fmbusy_quirk,
		.gun_type, .gun_sensor_delay
	);

	region_select u_region_select (
		.clk_sys, .RESET, .hdr_j, .hdr_u, .hdr_e, .hdr_ready,
		.auto_region, .region_priority, .ioctl_index,
		.region_req, .region_set
	);

	rom_write_pacer u_rom_write_pacer (
		.clk_sys, .RESET, .cart_download, .ioctl_wr, .ioctl_addr, .rom_wrack,
		.rom_wr, .ioctl_wait, .rom_sz
	);

	// SVP flag from the parser blocks backup RAM
	bram_sequencer u_bram_sequencer (
		.clk_sys, .RESET, .cart_download, .svp_quirk, .img_mounted, .img_readonly,
		.img_size, .bk_load, .bk_save, .sd_ack,
		.sd_rd, .sd_wr, .sd_lba, .bk_loading, .bk_busy
	);

endmodule

`default_nettype wire

//--- design/cart_macros.svh
// Cartridge loader constants
// Header offsets, product-code quirk table, gun delays and sector count
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH
`default_nettype none

// Header word addresses
`define HDR_REGION_ADDR_A 25'h1F0
`define HDR_REGION_ADDR_B 25'h1F2
`define HDR_END_ADDR      25'h200
`define CART_ID_ADDR_0    25'h182
`define CART_ID_ADDR_1    25'h184
`define CART_ID_ADDR_2    25'h186
`define CART_ID_ADDR_3    25'h188
`define CART_ID_ADDR_4    25'h18A
`define CART_ID_DONE_ADDR 25'h18C

////////////////////
// Quirk table
`define ID_SRAM_0   "T-081276" // NFL Quarterback Club
`define ID_SRAM_1   "T-81406 "
`define ID_EEPROM_0 "MK-1215 "
`define ID_EEPROM_1 "G-4060  "
`define ID_SVP_0    "MK-1229 " // Virtua Racing
`define ID_SVP_1    "G-7001  "
`define ID_FMBUSY_0 "T-35036 "
`define ID_FMBUSY_1 "T-25073 "

// Light-gun titles with type and sensor delay
`define ID_GUN_0    "MK-1533 "
`define GUN_TYPE_0  1'b0
`define GUN_DELAY_0 8'd100
`define ID_GUN_1    "T-95096-"
`define GUN_TYPE_1  1'b1
`define GUN_DELAY_1 8'd52
`define ID_GUN_2    "T-95136-"
`define GUN_TYPE_2  1'b1
`define GUN_DELAY_2 8'd30

`define GUN_DELAY_DEFAULT 8'd44
`define BRAM_LAST_SECTOR  7'd127

`default_nettype wire
`endif

//--- design/cart_pkg.sv
// Cartridge loader types
// Shared vector widths and state encodings
`default_nettype none

package cart_pkg;

	typedef logic [24:0] ioctl_addr_t;  // Byte address of a download word
	typedef logic [15:0] ioctl_data_t;  // Low byte is the lower address
	typedef logic [63:0] cart_id_t;     // Eight ASCII characters, first one on top
	typedef logic [6:0]  sector_t;
	typedef logic [63:0] img_size_t;
	typedef logic [7:0]  gun_delay_t;

	// Console region, encoding matches the menu status field
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	typedef enum logic [1:0] {
		FILE_EXT = 2'd0,
		HEADER   = 2'd1,
		DISABLED = 2'd2
	} auto_region_t;

	// Backup-RAM transfer state
	typedef enum logic {
		BK_IDLE = 1'b0,
		BK_XFER = 1'b1
	} bk_state_t;

endpackage

`default_nettype wire

//--- design/region_select.sv
// Region selector
// Picks the console region from header letters or download index
`default_nettype none

module region_select import cart_pkg::*; (
	input  wire logic         clk_sys,
	input  wire logic         RESET,
	input  wire logic         hdr_j,
	input  wire logic         hdr_u,
	input  wire logic         hdr_e,
	input  wire logic         hdr_ready,
	input  wire auto_region_t auto_region,
	input  wire logic [1:0]   region_priority,
	input  wire logic [7:0]   ioctl_index,
	output region_t           region_req,
	output logic              region_set
);

	logic ready_q;

	// First region present in the order wins, else the order's head
	function automatic region_t pick_region(input logic [1:0] prio, input logic j,
			input logic u, input logic e);
		region_t r;
		case (prio)
			2'd0:    r = u ? US : (e ? EU : (j ? JP : US)); // US>EU>JP
			2'd1:    r = e ? EU : (u ? US : (j ? JP : EU)); // EU>US>JP
			2'd2:    r = u ? US : (j ? JP : (e ? EU : US)); // US>JP>EU
			default: r = j ? JP : (u ? US : (e ? EU : JP)); // JP>US>EU
		endcase
		return r;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region_req <= JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			if (!ready_q && hdr_ready) begin
				case (auto_region)
					HEADER: begin
						region_set <= 1'b1;
						region_req <= pick_region(region_priority, hdr_j, hdr_u, hdr_e);
					end
					FILE_EXT: begin
						region_set <= |ioctl_index;
						region_req <= region_t'(ioctl_index[7:6]); // Region from file extension
					end
					default: ; // Auto region off
				endcase
			end
			if (ready_q && !hdr_ready) region_set <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/rom_write_pacer.sv
// ROM write pacer
// Toggle handshake toward ROM storage and loader wait line
`default_nettype none

module rom_write_pacer import cart_pkg::*; (
	input  wire logic        clk_sys,
	input  wire logic        RESET,
	input  wire logic        cart_download,
	input  wire logic        ioctl_wr,
	input  wire ioctl_addr_t ioctl_addr,
	input  wire logic        rom_wrack,
	output logic             rom_wr,
	output logic             ioctl_wait,
	output ioctl_addr_t      rom_sz
);

	logic dl_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q       <= 1'b0;
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			dl_q <= cart_download;
			if (cart_download && ioctl_wr) begin
				rom_wr     <= ~rom_wr; // One toggle per word
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && (rom_wr == rom_wrack)) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Last address of the download is the ROM size
	always_ff @(posedge clk_sys) begin
		if (dl_q && !cart_download) rom_sz <= ioctl_addr;
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the cartridge loader testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_cart_loader -f tb.f -o sim_cart_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_cart_loader > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tb.f
+incdir+design
design/cart_pkg.sv
design/cart_header_parser.sv
design/region_select.sv
design/rom_write_pacer.sv
design/bram_sequencer.sv
design/cart_loader_top.sv
tests/cart_loader_assert.sv
tests/tb_cart_loader.sv

//--- tests/cart_loader_assert.sv
// Cartridge loader assertions
// SD request exclusion, wait line cause and region strobe clearing
`default_nettype none

module cart_loader_assert (
	input wire logic clk_sys,
	input wire logic RESET,
	input wire logic sd_rd,
	input wire logic sd_wr,
	input wire logic ioctl_wait,
	input wire logic rom_wr,
	input wire logic region_set,
	input wire logic hdr_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	sd_excl: assert property (@(posedge clk_sys) disable iff (RESET) !(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr are high together");

	// Wait only rises together with a new ROM request
	wait_toggle: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(ioctl_wait) |-> (rom_wr != $past(rom_wr)))
		else $error("ioctl_wait rose without a rom_wr toggle");

	set_clear: assert property (@(posedge clk_sys) disable iff (RESET)
		(!hdr_ready && !$past(hdr_ready)) |-> !region_set)
		else $error("region_set high with hdr_ready low for two cycles");

endmodule

bind cart_loader_top cart_loader_assert u_cart_loader_assert (
	.clk_sys, .RESET, .sd_rd, .sd_wr, .ioctl_wait, .rom_wr, .region_set, .hdr_ready
);

`default_nettype wire

//--- tests/tb_cart_loader.sv
// Cartridge loader testbench
// Random downloads against a reference model of header, region, ROM pacing and backup RAM
`include "cart_macros.svh"
`default_nettype none

module tb_cart_loader import cart_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_dl = 10;
	localparam int max_words = 136;   // 0x100 to 0x200 plus up to 7 extra words
	localparam int word_gap = 10;     // Worst case cycles per download word
	localparam int sector_gap = 12;   // Worst case cycles per sector
	localparam int watchdog_cycles = n_dl * (max_words * word_gap + 2 * 128 * sector_gap) + 200;

	localparam cart_id_t known_ids [11] = '{`ID_SRAM_0, `ID_SRAM_1, `ID_EEPROM_0, `ID_EEPROM_1,
		`ID_SVP_0, `ID_SVP_1, `ID_FMBUSY_0, `ID_FMBUSY_1, `ID_GUN_0, `ID_GUN_1, `ID_GUN_2};
	localparam logic gun_types [3] = '{`GUN_TYPE_0, `GUN_TYPE_1, `GUN_TYPE_2};
	localparam gun_delay_t gun_delays [3] = '{`GUN_DELAY_0, `GUN_DELAY_1, `GUN_DELAY_2};
	localparam logic [7:0] letter_pool [8] = '{"J", "U", "E", "A", "4", "z", " ", "K"};

	logic clk_sys = 1'b0;
	logic RESET, cart_download, ioctl_wr, rom_wrack, img_mounted, img_readonly;
	logic bk_load, bk_save, sd_ack;
	ioctl_addr_t ioctl_addr, rom_sz;
	ioctl_data_t ioctl_data;
	logic [7:0] ioctl_index;
	auto_region_t auto_region;
	logic [1:0] region_priority;
	img_size_t img_size;
	logic ioctl_wait, rom_wr, region_set, gun_type, sd_rd, sd_wr, bk_loading, bk_busy;
	logic sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk;
	region_t region_req;
	gun_delay_t gun_sensor_delay;
	sector_t sd_lba;

	int ack_delay = 0;
	int ack_count = 0;
	logic [8:0] req_log [$];          // {bk_loading, sd_wr, sd_lba} per request
	logic [1:0] exp_req = 2'd0;
	logic exp_set;
	string cur_test;
	int test_errs, errors = 0, n_tests = 0, n_failed = 0;

	cart_loader_top u_cart_loader_top (.*);

	always #4 clk_sys = ~clk_sys;

	////////////////////
	// ROM storage model acknowledges after 1 to 6 cycles
	initial begin
		rom_wrack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (RESET === 1'b0 && rom_wr !== rom_wrack) begin
				ack_delay = 1 + int'($urandom % 6);
				repeat (ack_delay) @(negedge clk_sys);
				rom_wrack = rom_wr;
				ack_count++;
			end
		end
	end

	// SD side logs each request then pulses sd_ack
	initial begin
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (RESET === 1'b0 && (sd_rd === 1'b1 || sd_wr === 1'b1)) begin
				req_log.push_back({bk_loading, sd_wr, sd_lba});
				repeat (1 + int'($urandom % 5)) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat (1 + int'($urandom % 3)) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	initial begin
		#(watchdog_cycles * 8);
		$display("ERROR: watchdog expired before all downloads finished");
		$display("TEST FAILED");
		$finish;
	end

	////////////////////
	// Reporting
	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		string verdict;
		n_tests++;
		verdict = "ok";
		if (test_errs != 0) begin
			n_failed++;
			verdict = "failed";
		end
		$display("%-12s %s (%0d errors)", cur_test, verdict, test_errs);
	endtask

	task automatic report_mismatch(input string what, input logic [63:0] exp_val,
			input logic [63:0] act_val);
		$display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, what, exp_val, act_val);
		test_errs++;
		errors++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR in %s: %s", cur_test, msg);
		test_errs++;
		errors++;
	endtask

	////////////////////
	// Reference model
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		if (c == "J") return 3'b001;            // Bit index is the region code
		if (c == "U") return 3'b010;
		if (c >= "0" && c <= "Z") return 3'b100;
		return 3'b000;
	endfunction

	function automatic logic [1:0] expected_region(input logic [1:0] prio, input logic [2:0] flags);
		logic [1:0] order [3];
		logic [1:0] r;
		case (prio)
			2'd0:    order = '{US, EU, JP};
			2'd1:    order = '{EU, US, JP};
			2'd2:    order = '{US, JP, EU};
			default: order = '{JP, US, EU};
		endcase
		r = order[0];
		for (int k = 2; k >= 0; k--) begin
			if (flags[order[k]]) r = order[k];
		end
		return r;
	endfunction

	function automatic int table_index(input cart_id_t code);
		int idx;
		idx = -1;
		for (int k = 0; k < 11; k++) begin
			if (code == known_ids[k]) idx = k;
		end
		return idx;
	endfunction

	// Header word contents with code characters byte-swapped per word
	function automatic ioctl_data_t header_word(input ioctl_addr_t a, input cart_id_t code,
			input logic [23:0] letters);
		ioctl_data_t d;
		d = 16'($urandom);
		case (a)
			`HDR_REGION_ADDR_A: d = letters[15:0];
			`HDR_REGION_ADDR_B: d[7:0] = letters[23:16];
			`CART_ID_ADDR_0:    d[15:8] = code[63:56];
			`CART_ID_ADDR_1:    d = {code[47:40], code[55:48]};
			`CART_ID_ADDR_2:    d = {code[31:24], code[39:32]};
			`CART_ID_ADDR_3:    d = {code[15:8], code[23:16]};
			`CART_ID_ADDR_4:    d[7:0] = code[7:0];
			default: ;
		endcase
		return d;
	endfunction

	////////////////////
	// Loader and backup-RAM helpers
	task automatic write_word(input ioctl_addr_t addr, input ioctl_data_t data);
		logic prev_wr;
		int waited;
		prev_wr = rom_wr;
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		if (rom_wr === prev_wr) report_error($sformatf("no rom_wr toggle for address %0h", addr));
		if (ioctl_wait !== 1'b1) report_mismatch("ioctl_wait", 64'd1, 64'(ioctl_wait));
		waited = 0;
		while (ioctl_wait === 1'b1 && waited < 20) begin
			@(negedge clk_sys);
			waited++;
		end
		if (ioctl_wait !== 1'b0) report_error("ioctl_wait stayed high after the acknowledge");
		else if (waited != ack_delay + 1)
			report_mismatch("ioctl_wait cycles", 64'(ack_delay + 1), 64'(waited));
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (bk_busy === 1'b1 && n < 128 * sector_gap) begin
			@(negedge clk_sys);
			n++;
		end
		if (bk_busy !== 1'b0) report_error("bk_busy did not fall after a backup-RAM transfer");
		else if (bk_loading !== 1'b0) report_error("bk_loading stayed high after the transfer");
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic check_transfers(input int exp_count, input logic exp_wr);
		int bad;
		if (req_log.size() != exp_count) begin
			report_mismatch("sector requests", 64'(exp_count), 64'(req_log.size()));
		end else begin
			bad = -1;
			for (int k = exp_count - 1; k >= 0; k--) begin
				if (req_log[k] !== {!exp_wr, exp_wr, 7'(k)}) bad = k;
			end
			if (bad >= 0)
				report_mismatch($sformatf("request %0d", bad),
					64'({!exp_wr, exp_wr, 7'(bad)}), 64'(req_log[bad]));
		end
		req_log.delete();
	endtask

	task automatic run_download(input int i);
		cart_id_t code;
		logic [7:0] l0, l1, l2;
		int pick, idx, n_words, acks_before;
		ioctl_addr_t a, last_a;
		logic got_set, exp_ena, pulse_save, exp_gun;
		logic [1:0] got_req;
		logic [3:0] exp_quirk;
		gun_delay_t exp_delay;

		// Forced titles cover the SVP and auto load cases
		pick = int'($urandom % 11);
		code = {$urandom, $urandom};
		if (i == 0) code = `ID_GUN_1;
		else if (i == 1) code = `ID_SVP_0;
		else if (i == 5) code = `ID_SVP_1;
		else if (($urandom % 3) != 0) code = known_ids[pick];
		l0 = letter_pool[int'($urandom % 8)];
		l1 = letter_pool[int'($urandom % 8)];
		l2 = letter_pool[int'($urandom % 8)];
		ioctl_index = 8'($urandom);
		auto_region = auto_region_t'(2'($urandom % 3));
		region_priority = 2'($urandom);
		pick = int'($urandom % 4);
		img_mounted = (i == 0) || (pick != 0);
		pick = int'($urandom % 4);
		img_readonly = (i == 2) || (i != 0 && pick == 0);
		pick = int'($urandom % 4);
		img_size = (i == 0 || pick != 0) ? 64'($urandom) + 64'd512 : 64'd0;
		n_words = 129 + int'($urandom % 8);

		start_test($sformatf("download_%0d", i));
		acks_before = ack_count;
		cart_download = 1'b1;
		@(negedge clk_sys);
		a = 25'h100;
		last_a = a;
		for (int w = 0; w < n_words; w++) begin
			write_word(a, header_word(a, code, {l2, l1, l0}));
			last_a = a;
			a = a + 25'd2;
		end
		if (ack_count - acks_before != n_words)
			report_mismatch("rom_wr toggles", 64'(n_words), 64'(ack_count - acks_before));
		repeat (2) @(negedge clk_sys);
		got_set = region_set;   // Sampled while hdr_ready is still high
		got_req = region_req;
		cart_download = 1'b0;
		@(negedge clk_sys);
		if (rom_sz !== last_a) report_mismatch("rom_sz", 64'(last_a), 64'(rom_sz));
		finish_test();

		start_test($sformatf("header_%0d", i));
		case (auto_region)
			HEADER: begin
				exp_set = 1'b1;
				exp_req = expected_region(region_priority,
					letter_flags(l0) | letter_flags(l1) | letter_flags(l2));
			end
			FILE_EXT: begin
				exp_set = |ioctl_index;
				exp_req = ioctl_index[7:6];
			end
			default: exp_set = 1'b0; // Region left as it was
		endcase
		if (got_set !== exp_set) report_mismatch("region_set", 64'(exp_set), 64'(got_set));
		if (got_req !== exp_req) report_mismatch("region_req", 64'(exp_req), 64'(got_req));
		idx = table_index(code);
		exp_quirk = {idx == 6 || idx == 7, idx == 4 || idx == 5, idx == 2 || idx == 3,
			idx == 0 || idx == 1};
		exp_gun = 1'b0;
		exp_delay = `GUN_DELAY_DEFAULT;
		if (idx >= 8) begin
			exp_gun = gun_types[idx - 8];
			exp_delay = gun_delays[idx - 8];
		end
		if ({fmbusy_quirk, svp_quirk, eeprom_quirk, sram_quirk} !== exp_quirk)
			report_mismatch("quirk flags", 64'(exp_quirk),
				64'({fmbusy_quirk, svp_quirk, eeprom_quirk, sram_quirk}));
		if (gun_type !== exp_gun) report_mismatch("gun_type", 64'(exp_gun), 64'(gun_type));
		if (gun_sensor_delay !== exp_delay)
			report_mismatch("gun_sensor_delay", 64'(exp_delay), 64'(gun_sensor_delay));
		finish_test();

		// Auto load followed by one load or save request
		start_test($sformatf("backup_%0d", i));
		exp_ena = img_mounted && !img_readonly && !(idx == 4 || idx == 5);
		wait_idle();
		check_transfers((exp_ena && |img_size) ? 128 : 0, 1'b0);
		pulse_save = (i % 2 == 0);
		if (pulse_save) bk_save = 1'b1;
		else bk_load = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		bk_load = 1'b0;
		wait_idle();
		check_transfers(exp_ena ? 128 : 0, pulse_save);
		finish_test();
	endtask

	////////////////////
	// Main sequence
	initial begin
		void'($urandom(32'hfc7e_dcf9));
		RESET = 1'b1;
		cart_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		ioctl_index = '0;
		auto_region = DISABLED;
		region_priority = 2'd0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = '0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		repeat (4) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);

		for (int i = 0; i < n_dl; i++) run_download(i);

		$display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
